// ==== common/uart_pkg.sv ====
package uart_pkg;

   ////////////////////////////////////////
   // widths
   ////////////////////////////////////////

   localparam int ADDR_W = 3;             // cpu register address
   localparam int DATA_W = 32;            // cpu data bus
   localparam int DIV_W  = 16;            // baud divider and bit timers
   localparam int CHAR_W = 8;

   // start bit, data bits, one stop bit
   localparam int FRAME_BITS  = CHAR_W + 2;
   localparam int FRAME_CNT_W = $clog2(FRAME_BITS + 1);

   ////////////////////////////////////////
   // register map
   ////////////////////////////////////////

   // read only, 1 while a frame is on the line
   localparam logic [ADDR_W-1:0] UART_WRITE_WAIT = 3'd0;

   // clocks per bit
   localparam logic [ADDR_W-1:0] UART_DIV        = 3'd1;

   // write starts a frame, read pops the rx byte
   localparam logic [ADDR_W-1:0] UART_DATA       = 3'd2;

   localparam logic [ADDR_W-1:0] UART_READ_VALID = 3'd3;   // read only
   localparam logic [ADDR_W-1:0] UART_SOFT_RESET = 3'd4;   // write only

   ////////////////////////////////////////
   // reset and idle values
   ////////////////////////////////////////

   localparam logic [DIV_W-1:0]  DIV_RESET = DIV_W'(1);

   // bus value when nothing is being read
   localparam logic [DATA_W-1:0] READ_IDLE = '1;

endpackage

// ==== common/uart_ctrl_if.sv ====
`timescale 1ns/1ns

// control and status between the register block and the two serial engines
interface uart_ctrl_if (
   input logic clk
);
   import uart_pkg::*;

   logic [DIV_W-1:0]  divider;    // clocks per bit
   logic [CHAR_W-1:0] tx_char;    // valid with tx_load
   logic              tx_load;    // single cycle, starts a frame
   logic              tx_busy;
   logic [CHAR_W-1:0] rx_char;
   logic              rx_valid;
   logic              rx_take;    // single cycle, data register read
   logic              core_rst;   // hard reset or soft reset pulse

   // register block
   modport regs (
      input  clk,
      input  tx_busy, rx_char, rx_valid,
      output divider, tx_char, tx_load, rx_take, core_rst
   );

   // transmitter
   modport tx (
      input  clk,
      input  divider, tx_char, tx_load, core_rst,
      output tx_busy
   );

   // receiver
   modport rx (
      input  clk,
      input  divider, rx_take, core_rst,
      output rx_char, rx_valid
   );

endinterface

// ==== src/uart_regs.sv ====
`timescale 1ns/1ns

module uart_regs (
   input  logic                        clk,
   input  logic                        rst_int,
   input  logic [uart_pkg::ADDR_W-1:0] address,
   input  logic                        sel,
   input  logic                        read,
   input  logic                        write,
   input  logic [uart_pkg::DATA_W-1:0] data_in,
   output logic [uart_pkg::DATA_W-1:0] data_out,
   uart_ctrl_if.regs                   ctrl
);
   import uart_pkg::*;

   logic             wr_en;
   logic             rd_en;
   logic             div_wr;
   logic             data_wr;
   logic             soft_wr;
   logic             soft_rst_q;    // one cycle after the soft reset write
   logic             core_rst;
   logic [DIV_W-1:0] divider_q;

   assign wr_en = sel & write;
   assign rd_en = sel & read;

   ////////////////////////////////////////
   // write decode
   ////////////////////////////////////////

   always_comb
   begin
      div_wr  = 1'b0;
      data_wr = 1'b0;
      soft_wr = 1'b0;
      if (wr_en)
      begin
         case (address)
            UART_DIV:        div_wr  = 1'b1;
            UART_DATA:       data_wr = 1'b1;
            UART_SOFT_RESET: soft_wr = 1'b1;
            default:         ;                 // read only or unmapped
         endcase
      end
   end

   // registered so core_rst has no decode glitches
   always_ff @(posedge clk or posedge rst_int)
   begin
      if (rst_int)
         soft_rst_q <= 1'b0;
      else
         soft_rst_q <= soft_wr;
   end

   assign core_rst = rst_int | soft_rst_q;

   // divider, low half of the bus word
   always_ff @(posedge clk or posedge core_rst)
   begin
      if (core_rst)
         divider_q <= DIV_RESET;
      else if (div_wr)
         divider_q <= data_in[DIV_W-1:0];
   end

   // frame starts at the write edge itself
   assign ctrl.divider  = divider_q;
   assign ctrl.tx_char  = data_in[CHAR_W-1:0];
   assign ctrl.tx_load  = data_wr;
   assign ctrl.core_rst = core_rst;

   ////////////////////////////////////////
   // read mux
   ////////////////////////////////////////

   // popping the rx byte clears valid at the read edge
   assign ctrl.rx_take = rd_en && (address == UART_DATA);

   always_comb
   begin
      data_out = READ_IDLE;
      if (rd_en)
      begin
         case (address)
            UART_WRITE_WAIT: data_out = DATA_W'(ctrl.tx_busy);
            UART_DIV:        data_out = DATA_W'(divider_q);
            UART_DATA:       data_out = DATA_W'(ctrl.rx_char);
            UART_READ_VALID: data_out = DATA_W'(ctrl.rx_valid);
            default:         data_out = READ_IDLE;
         endcase
      end
   end

endmodule

// ==== uart_tx/uart_tx.sv ====
`timescale 1ns/1ns

module uart_tx (
   input  logic    clk,
   uart_ctrl_if.tx ctrl,
   output logic    ser_tx
);
   import uart_pkg::*;

   logic [DIV_W-1:0]       div_cnt;    // clocks into the current bit
   logic [FRAME_CNT_W-1:0] bit_cnt;    // bits left in the frame
   logic [FRAME_BITS-1:0]  shreg;
   logic                   busy;
   logic                   bit_end;

   assign busy = (bit_cnt != '0);

   // >= so a divider lowered mid frame cannot hang the counter
   assign bit_end = busy && (div_cnt >= ctrl.divider);

   ////////////////////////////////////////
   // bit timing
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge ctrl.core_rst)
   begin
      if (ctrl.core_rst)
         div_cnt <= '0;
      else if (ctrl.tx_load)
         div_cnt <= DIV_W'(1);          // write edge is the first clock of the start bit
      else if (bit_end)
         div_cnt <= DIV_W'(1);
      else if (busy)
         div_cnt <= div_cnt + 1'b1;
   end

   always_ff @(posedge clk or posedge ctrl.core_rst)
   begin
      if (ctrl.core_rst)
         bit_cnt <= '0;
      else if (ctrl.tx_load)
         bit_cnt <= FRAME_CNT_W'(FRAME_BITS);   // a write mid frame restarts it
      else if (bit_end)
         bit_cnt <= bit_cnt - 1'b1;
   end

   ////////////////////////////////////////
   // frame shifter
   ////////////////////////////////////////

   // lsb goes out first, ones fill in behind the stop bit
   always_ff @(posedge clk or posedge ctrl.core_rst)
   begin
      if (ctrl.core_rst)
         shreg <= '1;                   // idle line is high
      else if (ctrl.tx_load)
         shreg <= {1'b1, ctrl.tx_char, 1'b0};
      else if (bit_end)
         shreg <= {1'b1, shreg[FRAME_BITS-1:1]};
   end

   assign ser_tx       = shreg[0];
   assign ctrl.tx_busy = busy;

endmodule

// ==== uart_rx/uart_rx.sv ====
`timescale 1ns/1ns

module uart_rx (
   input logic     clk,
   uart_ctrl_if.rx ctrl,
   input logic     ser_rx
);
   import uart_pkg::*;

   logic [1:0]        sync;         // [1] is the synchronized line
   logic              rx_line;
   logic [3:0]        state;        // 0 idle, 1..8 data bits, 9 stop
   logic [DIV_W-1:0]  div_cnt;
   logic [DIV_W:0]    first_wait;   // start edge to middle of bit 0
   logic              bit_end;
   logic              sample;
   logic              done;
   logic [CHAR_W-1:0] shreg;
   logic [CHAR_W-1:0] rx_char_q;
   logic              rx_valid_q;

   // two flops against metastability
   always_ff @(posedge clk or posedge ctrl.core_rst)
   begin
      if (ctrl.core_rst)
         sync <= '1;
      else
         sync <= {sync[0], ser_rx};
   end

   assign rx_line = sync[1];

   ////////////////////////////////////////
   // bit timing
   ////////////////////////////////////////

   // one divider plus half a divider, rounded down
   // half bit of the start is folded in here, so divider 1 still lands in the cell
   assign first_wait = {1'b0, ctrl.divider} + (({1'b0, ctrl.divider} - 1'b1) >> 1);

   assign bit_end = (state == 4'd1) ? ({1'b0, div_cnt} >= first_wait)
                                    : (div_cnt >= ctrl.divider);

   assign sample = bit_end && (state != 4'd0) && (state <= 4'd8);
   assign done   = bit_end && (state == 4'd9);   // middle of the stop bit

   always_ff @(posedge clk or posedge ctrl.core_rst)
   begin
      if (ctrl.core_rst)
      begin
         state   <= 4'd0;
         div_cnt <= '0;
      end
      else if (state == 4'd0)
      begin
         div_cnt <= DIV_W'(1);
         if (!rx_line)                 // start bit seen
            state <= 4'd1;
      end
      else if (bit_end)
      begin
         div_cnt <= DIV_W'(1);
         state   <= (state == 4'd9) ? 4'd0 : state + 4'd1;
      end
      else
         div_cnt <= div_cnt + 1'b1;
   end

   ////////////////////////////////////////
   // data path and valid flag
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (sample)
         shreg <= {rx_line, shreg[CHAR_W-1:1]};   // lsb arrives first
   end

   always_ff @(posedge clk)
   begin
      if (done)
         rx_char_q <= shreg;       // overwrites an unread byte
   end

   always_ff @(posedge clk or posedge ctrl.core_rst)
   begin
      if (ctrl.core_rst)
         rx_valid_q <= 1'b0;
      else if (done)
         rx_valid_q <= 1'b1;       // new byte beats a read on the same edge
      else if (ctrl.rx_take)
         rx_valid_q <= 1'b0;
   end

   assign ctrl.rx_char  = rx_char_q;
   assign ctrl.rx_valid = rx_valid_q;

endmodule

// ==== src/uart_top.sv ====
`timescale 1ns/1ns

module uart_top (
   input  logic                        clk,
   input  logic                        rst_int,

   // cpu side
   input  logic [uart_pkg::ADDR_W-1:0] address,
   input  logic                        sel,
   input  logic                        read,
   input  logic                        write,
   input  logic [uart_pkg::DATA_W-1:0] data_in,
   output logic [uart_pkg::DATA_W-1:0] data_out,

   // serial line
   output logic                        ser_tx,
   input  logic                        ser_rx
);

   uart_ctrl_if ctrl (
      .clk (clk)
   );

   // register file, reset generation
   uart_regs regs_inst (
      .clk      (clk),
      .rst_int  (rst_int),
      .address  (address),
      .sel      (sel),
      .read     (read),
      .write    (write),
      .data_in  (data_in),
      .data_out (data_out),
      .ctrl     (ctrl.regs)
   );

   uart_tx tx_inst (
      .clk    (clk),
      .ctrl   (ctrl.tx),
      .ser_tx (ser_tx)
   );

   // line goes through the synchronizer inside
   uart_rx rx_inst (
      .clk    (clk),
      .ctrl   (ctrl.rx),
      .ser_rx (ser_rx)
   );

endmodule

// ==== verif/uart_properties.sv ====
`timescale 1ns/1ns

module uart_properties (
   input logic                        clk,
   input logic                        rst_int,
   input logic                        sel,
   input logic                        read,
   input logic [uart_pkg::DATA_W-1:0] data_out,
   input logic                        ser_tx,
   input logic                        tx_busy,
   input logic                        rx_valid,
   input logic                        rx_take,
   input logic                        core_rst
);
   import uart_pkg::*;

   // line idles high between frames
   idle_line_high: assert property (@(posedge clk) disable iff (rst_int)
      !tx_busy |-> ser_tx)
      else $error("ser_tx low while the transmitter is idle");

   // soft reset clears valid asynchronously, so core_rst is still high when sampled
   valid_clear_cause: assert property (@(posedge clk) disable iff (rst_int)
      $fell(rx_valid) |-> ($past(rx_take) || $past(core_rst) || core_rst))
      else $error("rx_valid dropped without a data read or a reset");

   idle_bus_value: assert property (@(posedge clk)
      !(sel && read) |-> (data_out == READ_IDLE))
      else $error("data_out not at its idle value outside a read");

endmodule

bind uart_top uart_properties props_inst (
   .clk      (clk),
   .rst_int  (rst_int),
   .sel      (sel),
   .read     (read),
   .data_out (data_out),
   .ser_tx   (ser_tx),
   .tx_busy  (ctrl.tx_busy),
   .rx_valid (ctrl.rx_valid),
   .rx_take  (ctrl.rx_take),
   .core_rst (ctrl.core_rst)
);

// ==== verif/uart_tb.sv ====
`timescale 1ns/1ns

module uart_tb;
   import uart_pkg::*;

   localparam int                CLK_PERIOD    = 40;
   localparam int                ROWS          = 5;
   localparam int                SOFT_ROW      = 4;
   localparam logic [ADDR_W-1:0] UNMAPPED_ADDR = 3'd5;

   // stimulus table, divider and byte per row
   localparam int                ROW_DIV  [ROWS] = '{1, 2, 3, 5, 4};
   localparam logic [CHAR_W-1:0] ROW_CHAR [ROWS] = '{8'h55, 8'hA3, 8'h00, 8'hFF, 8'h3C};

   logic              clk = 1'b0;
   logic              rst_int;
   logic [ADDR_W-1:0] address;
   logic              sel;
   logic              read;
   logic              write;
   logic [DATA_W-1:0] data_in;
   logic [DATA_W-1:0] data_out;
   logic              ser_tx;
   logic              ser_rx;
   int                fail_count = 0;

   assign ser_rx = ser_tx;               // loopback

   always #(CLK_PERIOD / 2) clk = ~clk;

   uart_top uart_top_inst (
      .clk      (clk),
      .rst_int  (rst_int),
      .address  (address),
      .sel      (sel),
      .read     (read),
      .write    (write),
      .data_in  (data_in),
      .data_out (data_out),
      .ser_tx   (ser_tx),
      .ser_rx   (ser_rx)
   );

   ////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("Simulation finished: FAIL");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_word(input string name, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
      if (actual !== expected)
      begin
         fail_count++;
         abort_run($sformatf("FAIL at %0t ns: %s expected %h, got %h",
                             $time, name, expected, actual));
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      if (actual !== expected)
      begin
         fail_count++;
         abort_run($sformatf("FAIL at %0t ns: %s expected %b, got %b",
                             $time, name, expected, actual));
      end
   endtask

   ////////////////////////////////////////
   // bus tasks
   ////////////////////////////////////////

   task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] value);
      @(posedge clk);
      address <= addr;
      data_in <= value;
      sel     <= 1'b1;
      write   <= 1'b1;
      @(posedge clk);                    // write edge
      sel     <= 1'b0;
      write   <= 1'b0;
   endtask

   // data_out taken mid cycle, strobe may be held low
   task automatic bus_cycle(input logic [ADDR_W-1:0] addr, input logic strobe,
                            output logic [DATA_W-1:0] value);
      @(posedge clk);
      address <= addr;
      sel     <= 1'b1;
      read    <= strobe;
      @(negedge clk);
      value = data_out;
      @(posedge clk);
      sel     <= 1'b0;
      read    <= 1'b0;
   endtask

   task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] value);
      bus_cycle(addr, 1'b1, value);
   endtask

   task automatic expect_read(input logic [ADDR_W-1:0] addr, input string name,
                              input logic [DATA_W-1:0] expected);
      logic [DATA_W-1:0] value;
      bus_read(addr, value);
      check_word(name, expected, value);
   endtask

   ////////////////////////////////////////
   // frame and loopback checks
   ////////////////////////////////////////

   // line level at bit k of a frame: start low, data lsb first, stop high
   function automatic logic frame_bit(input logic [CHAR_W-1:0] ch, input int k);
      if (k == 0)
         return 1'b0;
      else if (k > CHAR_W)
         return 1'b1;
      else
         return ch[k-1];
   endfunction

   // starts on the write edge of the data register
   task automatic check_frame(input int div, input logic [CHAR_W-1:0] ch);
      int cyc;
      int target;
      cyc     = 0;
      address <= UART_WRITE_WAIT;        // busy flag watched for the whole frame
      sel     <= 1'b1;
      read    <= 1'b1;
      for (int k = 0; k < FRAME_BITS; k++)
      begin
         target = ((2 * k + 1) * div) / 2;
         while (cyc < target)
         begin
            @(posedge clk);
            cyc++;
         end
         @(negedge clk);                 // middle of bit k, on the low phase
         check_bit($sformatf("ser_tx bit %0d", k), frame_bit(ch, k), ser_tx);
         check_word("write_wait in frame", 32'd1, data_out);
      end
      while (cyc < FRAME_BITS * div)
      begin
         @(posedge clk);
         cyc++;
      end
      @(negedge clk);
      check_word("write_wait after frame", 32'd0, data_out);
      check_bit("ser_tx after frame", 1'b1, ser_tx);
      @(posedge clk);
      sel  <= 1'b0;
      read <= 1'b0;
   endtask

   // polls the valid flag for up to 12 bit times
   task automatic wait_rx_valid(input int div, input logic [CHAR_W-1:0] ch);
      logic [DATA_W-1:0] value;
      int                tries;
      tries = 0;
      value = '0;
      while (value !== 32'd1 && tries < 12 * div)
      begin
         bus_read(UART_READ_VALID, value);
         tries += 2;                     // two clocks per poll
      end
      if (value !== 32'd1)
         abort_run($sformatf("receive valid never rose for byte %h", ch));
   endtask

   task automatic check_loopback(input int div, input logic [CHAR_W-1:0] ch);
      wait_rx_valid(div, ch);
      expect_read(UART_DATA, "rx data", {24'h0, ch});
      expect_read(UART_READ_VALID, "read_valid after data read", 32'd0);
   endtask

   function automatic int watchdog_cycles();
      int total;
      total = 200;
      for (int r = 0; r < ROWS; r++)
         total += 12 * FRAME_BITS * ROW_DIV[r];
      return total;
   endfunction

   initial
   begin
      #(watchdog_cycles() * CLK_PERIOD);
      abort_run("timeout: the run did not finish in the expected time");
   end

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////

   initial
   begin
      logic [DATA_W-1:0] value;
      rst_int = 1'b1;
      address = '0;
      sel     = 1'b0;
      read    = 1'b0;
      write   = 1'b0;
      data_in = '0;
      repeat (4) @(posedge clk);
      rst_int <= 1'b0;

      expect_read(UART_DIV, "div after reset", 32'd1);
      expect_read(UART_WRITE_WAIT, "write_wait after reset", 32'd0);
      expect_read(UART_READ_VALID, "read_valid after reset", 32'd0);
      @(negedge clk);
      check_bit("ser_tx after reset", 1'b1, ser_tx);
      expect_read(UNMAPPED_ADDR, "unmapped read", 32'hFFFF_FFFF);
      bus_cycle(UART_DIV, 1'b0, value);  // select without read strobe
      check_word("read strobe low", 32'hFFFF_FFFF, value);

      for (int r = 0; r < ROWS; r++)
      begin
         bus_write(UART_DIV, {16'hA5C3, 16'(ROW_DIV[r])});   // upper half is dropped
         expect_read(UART_DIV, "div readback", {16'h0, 16'(ROW_DIV[r])});
         bus_write(UART_DATA, {24'h0, ROW_CHAR[r]});
         check_frame(ROW_DIV[r], ROW_CHAR[r]);
         check_loopback(ROW_DIV[r], ROW_CHAR[r]);
      end

      // soft reset in the middle of a frame, with an unread byte waiting
      bus_write(UART_DIV, {16'h0, 16'(ROW_DIV[SOFT_ROW])});
      bus_write(UART_DATA, {24'h0, ROW_CHAR[SOFT_ROW]});
      wait_rx_valid(ROW_DIV[SOFT_ROW], ROW_CHAR[SOFT_ROW]);   // left unread
      bus_write(UART_DATA, {24'h0, ROW_CHAR[SOFT_ROW]});
      repeat (7 * ROW_DIV[SOFT_ROW]) @(posedge clk);
      expect_read(UART_WRITE_WAIT, "write_wait mid frame", 32'd1);
      @(negedge clk);
      check_bit("ser_tx before soft reset", 1'b0, ser_tx);   // data bit 6 of the byte
      bus_write(UART_SOFT_RESET, 32'd0);    // lands in data bit 7, also low
      repeat (2) @(posedge clk);
      @(negedge clk);
      check_bit("ser_tx after soft reset", 1'b1, ser_tx);
      expect_read(UART_WRITE_WAIT, "write_wait after soft reset", 32'd0);
      expect_read(UART_READ_VALID, "read_valid after soft reset", 32'd0);
      expect_read(UART_DIV, "div after soft reset", 32'd1);

      if (fail_count == 0)
      begin
         $display("Simulation finished: PASS");
      end
      else
      begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// ==== compile.f ====
common/uart_pkg.sv
common/uart_ctrl_if.sv
src/uart_regs.sv
uart_tx/uart_tx.sv
uart_rx/uart_rx.sv
src/uart_top.sv
verif/uart_properties.sv
verif/uart_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then scan the log
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal --top-module uart_tb -f compile.f \
   --Mdir obj_dir -o uart_tb_sim

status=0
./obj_dir/uart_tb_sim > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log || [ "$status" -ne 0 ]; then
   echo "simulation failed, see sim.log"
   exit 1
fi

echo "simulation passed"
